// File: rtl/scene_pkg.sv
package scene_pkg;

    localparam logic [3:0] OP_CREATE_VERT = 4'd1;
    localparam logic [3:0] OP_CREATE_TRI  = 4'd2;
    localparam logic [3:0] OP_CREATE_INST = 4'd3;
    localparam logic [3:0] OP_UPDATE_INST = 4'd4;

    localparam int VTX_W     = 108;            // 3 x 32-bit coords, 3 x 4-bit attributes
    localparam int TRI_W     = 24;             // Three 8-bit vertex indices
    localparam int TRANS_W   = 288;            // Nine 32-bit words
    localparam int VTX_NIB   = VTX_W / 4;
    localparam int TRI_NIB   = TRI_W / 4;
    localparam int TRANS_NIB = TRANS_W / 4;

    localparam int VERT_DEPTH = 1024;
    localparam int TRI_DEPTH  = 1024;
    localparam int VADDR_W    = 10;
    localparam int TADDR_W    = 10;
    localparam int ADDR_W     = (VADDR_W > TADDR_W) ? VADDR_W : TADDR_W;

    localparam int ARG_W    = 16;
    localparam int ARG_NIB  = ARG_W / 4;
    localparam int CNT_W    = 8;
    localparam int ID_W     = 8;
    localparam int ID_NIB   = ID_W / 4;        // Update instance sends only the id
    localparam int STATUS_W = 4;
    localparam int REPLY_W  = ID_W + STATUS_W;

    localparam logic [3:0] REPLY_LEN_FULL   = 4'd12;
    localparam logic [3:0] REPLY_LEN_STATUS = 4'd4;

    localparam logic [2:0] DEC_OP    = 3'd0;
    localparam logic [2:0] DEC_ARG   = 3'd1;
    localparam logic [2:0] DEC_REC   = 3'd2;
    localparam logic [2:0] DEC_REPLY = 3'd3;
    localparam logic [2:0] DEC_WAIT  = 3'd4;

    typedef struct packed {
        logic [ARG_W-CNT_W-1:0] unused;
        logic [CNT_W-1:0]       count;
    } arg_count_t;

    typedef struct packed {
        logic [ID_W-1:0] vbuf_id;
        logic [ID_W-1:0] tbuf_id;
    } arg_ref_t;

    typedef union packed {
        arg_count_t cnt;                       // Create vertex / triangle
        arg_ref_t   refs;                      // Create instance
    } arg_word_u;

endpackage

// File: rtl/spi_cmd_decoder.sv
`timescale 1ns/1ps

module spi_cmd_decoder (
    input  logic                              sck,
    input  logic                              rst,
    input  logic                              cs_n_i,
    input  logic [3:0]                        mosi_i,
    input  logic                              accept_i,
    input  logic [scene_pkg::ADDR_W-1:0]      base_addr_i,
    input  logic [scene_pkg::ID_W-1:0]        new_id_i,
    input  logic [scene_pkg::STATUS_W-1:0]    status_i,
    input  logic                              busy_i,
    output logic                              arg_valid_o,
    output scene_pkg::arg_word_u              arg_o,
    output logic [3:0]                        op_o,
    output logic                              vert_we_o,
    output logic                              tri_we_o,
    output logic                              inst_we_o,
    output logic [scene_pkg::ADDR_W-1:0]      rec_addr_o,
    output logic [scene_pkg::VTX_W-1:0]       vert_data_o,
    output logic [scene_pkg::TRI_W-1:0]       tri_data_o,
    output logic [scene_pkg::TRANS_W-1:0]     inst_data_o,
    output logic [scene_pkg::ID_W-1:0]        inst_id_o,
    output logic [scene_pkg::ID_W-1:0]        inst_vbuf_o,
    output logic [scene_pkg::ID_W-1:0]        inst_tbuf_o,
    output logic                              reply_start_o,
    output logic [3:0]                        reply_len_o,
    output logic [scene_pkg::REPLY_W-1:0]     reply_val_o
);

    logic [2:0]                         state;
    logic [3:0]                         op_q;
    logic [scene_pkg::ARG_W-5:0]        arg_sr;
    scene_pkg::arg_word_u               arg_q;
    logic [6:0]                         nib_cnt;        // Up to 72 nibbles per transform
    logic [scene_pkg::CNT_W-1:0]        rec_cnt;
    logic [scene_pkg::CNT_W-1:0]        rec_last;
    logic [scene_pkg::ADDR_W-1:0]       rec_idx;
    logic [scene_pkg::TRANS_W-1:0]      rec_sr;         // Shared by all record kinds
    logic                               is_update;
    logic                               is_inst;
    logic                               op_known;
    logic                               fetch;
    logic                               arg_done;
    logic                               rec_done;
    logic                               we_ok;

    assign is_update = (op_q == scene_pkg::OP_UPDATE_INST);
    assign is_inst   = (op_q == scene_pkg::OP_CREATE_INST) || is_update;
    assign op_known  = mosi_i inside {scene_pkg::OP_CREATE_VERT, scene_pkg::OP_CREATE_TRI,
                                      scene_pkg::OP_CREATE_INST, scene_pkg::OP_UPDATE_INST};

    // Opcode is taken in fetch state, or right after the last reply bit
    assign fetch = (state == scene_pkg::DEC_OP) || (state == scene_pkg::DEC_WAIT && !busy_i);

    assign arg_done = is_update ? (nib_cnt == scene_pkg::ID_NIB - 1)
                                : (nib_cnt == scene_pkg::ARG_NIB - 1);

    always_comb begin
        case (op_q)
            scene_pkg::OP_CREATE_VERT: rec_done = (nib_cnt == scene_pkg::VTX_NIB - 1);
            scene_pkg::OP_CREATE_TRI:  rec_done = (nib_cnt == scene_pkg::TRI_NIB - 1);
            default:                   rec_done = (nib_cnt == scene_pkg::TRANS_NIB - 1);
        endcase
    end

    assign rec_last = is_inst ? '0 : arg_q.cnt.count - 1'b1;
    assign rec_idx  = {{(scene_pkg::ADDR_W - scene_pkg::CNT_W){1'b0}}, rec_cnt};
    assign we_ok    = accept_i || is_update;     // Update has no allocation

    // Allocator samples the word on the edge that takes its last nibble
    assign arg_o       = {arg_sr, mosi_i};
    assign arg_valid_o = (state == scene_pkg::DEC_ARG) && !cs_n_i && arg_done && !is_update;
    assign op_o        = op_q;

    assign vert_data_o = rec_sr[scene_pkg::VTX_W-1:0];
    assign tri_data_o  = rec_sr[scene_pkg::TRI_W-1:0];
    assign inst_data_o = rec_sr;
    assign inst_vbuf_o = arg_q.refs.vbuf_id;
    assign inst_tbuf_o = arg_q.refs.tbuf_id;

    // Allocator answer is stable by the time the serializer loads
    assign reply_val_o = {new_id_i, status_i};

    always_ff @(posedge sck) begin
        vert_we_o     <= 1'b0;
        tri_we_o      <= 1'b0;
        inst_we_o     <= 1'b0;
        reply_start_o <= 1'b0;
        if (rst || cs_n_i) begin
            state   <= scene_pkg::DEC_OP;          // Chip select high aborts the command
            op_q    <= '0;
            nib_cnt <= '0;
            rec_cnt <= '0;
        end else begin
            case (state)
                scene_pkg::DEC_OP, scene_pkg::DEC_WAIT: begin
                    if (fetch) begin
                        op_q    <= mosi_i;
                        nib_cnt <= '0;
                        if (op_known) begin
                            state <= scene_pkg::DEC_ARG;
                        end else begin
                            state <= scene_pkg::DEC_OP;
                        end
                    end
                end

                scene_pkg::DEC_ARG: begin
                    arg_sr <= {arg_sr[scene_pkg::ARG_W-9:0], mosi_i};
                    if (arg_done) begin
                        nib_cnt <= '0;
                        rec_cnt <= '0;
                        arg_q   <= arg_o;
                        if (is_update) begin
                            inst_id_o <= {arg_sr[3:0], mosi_i};
                        end
                        if (!is_inst && arg_o.cnt.count == '0) begin
                            reply_start_o <= 1'b1;   // Empty buffer, reply at once
                            reply_len_o   <= scene_pkg::REPLY_LEN_FULL;
                            state         <= scene_pkg::DEC_REPLY;
                        end else begin
                            state <= scene_pkg::DEC_REC;
                        end
                    end else begin
                        nib_cnt <= nib_cnt + 1'b1;
                    end
                end

                scene_pkg::DEC_REC: begin
                    rec_sr <= {rec_sr[scene_pkg::TRANS_W-5:0], mosi_i};
                    if (rec_done) begin
                        nib_cnt    <= '0;
                        rec_addr_o <= base_addr_i + rec_idx;
                        vert_we_o  <= we_ok && (op_q == scene_pkg::OP_CREATE_VERT);
                        tri_we_o   <= we_ok && (op_q == scene_pkg::OP_CREATE_TRI);
                        inst_we_o  <= we_ok && is_inst;
                        if (op_q == scene_pkg::OP_CREATE_INST) begin
                            inst_id_o <= new_id_i;
                        end
                        if (rec_cnt == rec_last) begin
                            reply_start_o <= 1'b1;
                            reply_len_o   <= is_update ? scene_pkg::REPLY_LEN_STATUS
                                                       : scene_pkg::REPLY_LEN_FULL;
                            state         <= scene_pkg::DEC_REPLY;
                        end else begin
                            rec_cnt <= rec_cnt + 1'b1;
                        end
                    end else begin
                        nib_cnt <= nib_cnt + 1'b1;
                    end
                end

                scene_pkg::DEC_REPLY: begin
                    state <= scene_pkg::DEC_WAIT;    // Serializer loads on this edge
                end

                default: begin
                    state <= scene_pkg::DEC_OP;
                end
            endcase
        end
    end

endmodule

// File: rtl/buffer_allocator.sv
`timescale 1ns/1ps

module buffer_allocator (
    input  logic                              sck,
    input  logic                              rst,
    input  logic                              arg_valid_i,
    input  scene_pkg::arg_word_u              arg_i,
    input  logic [3:0]                        op_i,
    output logic                              accept_o,
    output logic [scene_pkg::ADDR_W-1:0]      base_addr_o,
    output logic [scene_pkg::ID_W-1:0]        new_id_o,
    output logic [scene_pkg::STATUS_W-1:0]    status_o
);

    logic [scene_pkg::VADDR_W:0]    vert_base;      // One extra bit to hold a full memory
    logic [scene_pkg::TADDR_W:0]    tri_base;
    logic [scene_pkg::VADDR_W:0]    vert_end;
    logic [scene_pkg::TADDR_W:0]    tri_end;
    logic [scene_pkg::ID_W-1:0]     vbuf_id;
    logic [scene_pkg::ID_W-1:0]     tbuf_id;
    logic [scene_pkg::ID_W-1:0]     inst_id;
    logic                           last_rej;

    assign vert_end = vert_base
                    + {{(scene_pkg::VADDR_W + 1 - scene_pkg::CNT_W){1'b0}}, arg_i.cnt.count};
    assign tri_end  = tri_base
                    + {{(scene_pkg::TADDR_W + 1 - scene_pkg::CNT_W){1'b0}}, arg_i.cnt.count};

    always_ff @(posedge sck) begin
        if (rst) begin
            vert_base   <= '0;
            tri_base    <= '0;
            vbuf_id     <= '0;
            tbuf_id     <= '0;
            inst_id     <= 8'd1;                    // Id 0 belongs to the camera
            last_rej    <= 1'b0;
            accept_o    <= 1'b0;
            base_addr_o <= '0;
            new_id_o    <= '0;
        end else if (arg_valid_i) begin
            case (op_i)
                scene_pkg::OP_CREATE_VERT: begin
                    accept_o <= (vert_end <= scene_pkg::VERT_DEPTH);
                    last_rej <= (vert_end > scene_pkg::VERT_DEPTH);
                    if (vert_end <= scene_pkg::VERT_DEPTH) begin
                        base_addr_o <= vert_base[scene_pkg::ADDR_W-1:0];
                        new_id_o    <= vbuf_id;
                        vbuf_id     <= vbuf_id + 1'b1;
                        vert_base   <= vert_end;
                    end else begin
                        new_id_o <= '1;
                    end
                end
                scene_pkg::OP_CREATE_TRI: begin
                    accept_o <= (tri_end <= scene_pkg::TRI_DEPTH);
                    last_rej <= (tri_end > scene_pkg::TRI_DEPTH);
                    if (tri_end <= scene_pkg::TRI_DEPTH) begin
                        base_addr_o <= tri_base[scene_pkg::ADDR_W-1:0];
                        new_id_o    <= tbuf_id;
                        tbuf_id     <= tbuf_id + 1'b1;
                        tri_base    <= tri_end;
                    end else begin
                        new_id_o <= '1;
                    end
                end
                scene_pkg::OP_CREATE_INST: begin
                    accept_o <= 1'b1;
                    last_rej <= 1'b0;
                    new_id_o <= inst_id;
                    if (inst_id != '1) begin
                        inst_id <= inst_id + 1'b1;  // Sticks at 255
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign status_o = {vert_base == scene_pkg::VERT_DEPTH,
                       tri_base == scene_pkg::TRI_DEPTH,
                       inst_id == '1,
                       last_rej};

endmodule

// File: rtl/reply_serializer.sv
`timescale 1ns/1ps

module reply_serializer (
    input  logic                              sck,
    input  logic                              rst,
    input  logic                              cs_n_i,
    input  logic                              start_i,
    input  logic [3:0]                        len_i,
    input  logic [scene_pkg::REPLY_W-1:0]     value_i,
    output logic                              miso_o,
    output logic                              busy_o
);

    logic [scene_pkg::REPLY_W-1:0]  shift_q;
    logic [scene_pkg::REPLY_W-1:0]  aligned;
    logic [3:0]                     bits_left;

    // Move the selected field up against the MSB
    assign aligned = value_i << (scene_pkg::REPLY_W - len_i);

    always_ff @(posedge sck) begin
        if (rst || cs_n_i) begin
            bits_left <= '0;
            miso_o    <= 1'b0;
        end else if (start_i) begin
            bits_left <= len_i - 1'b1;              // First bit goes out now
            miso_o    <= aligned[scene_pkg::REPLY_W-1];
        end else if (bits_left != '0) begin
            bits_left <= bits_left - 1'b1;
            miso_o    <= shift_q[scene_pkg::REPLY_W-1];
        end else begin
            miso_o    <= 1'b0;                      // Idle line
        end
    end

    always_ff @(posedge sck) begin
        if (start_i) begin
            shift_q <= aligned << 1;
        end else begin
            shift_q <= shift_q << 1;
        end
    end

    // Low once the final bit is on the line
    assign busy_o = (bits_left != '0);

endmodule

// File: rtl/raster_spi_link.sv
`timescale 1ns/1ps

module raster_spi_link (
    input  logic                              sck,
    input  logic                              rst,
    input  logic                              cs_n_i,
    input  logic [3:0]                        mosi_i,
    output logic                              miso_o,
    output logic                              vert_we_o,
    output logic [scene_pkg::VADDR_W-1:0]     vert_addr_o,
    output logic [scene_pkg::VTX_W-1:0]       vert_data_o,
    output logic                              tri_we_o,
    output logic [scene_pkg::TADDR_W-1:0]     tri_addr_o,
    output logic [scene_pkg::TRI_W-1:0]       tri_data_o,
    output logic                              inst_we_o,
    output logic [scene_pkg::ID_W-1:0]        inst_id_o,
    output logic [scene_pkg::ID_W-1:0]        inst_vbuf_o,
    output logic [scene_pkg::ID_W-1:0]        inst_tbuf_o,
    output logic [scene_pkg::TRANS_W-1:0]     inst_data_o
);

    logic                               arg_valid;
    scene_pkg::arg_word_u               arg;
    logic [3:0]                         op;
    logic                               accept;
    logic [scene_pkg::ADDR_W-1:0]       base_addr;
    logic [scene_pkg::ID_W-1:0]         new_id;
    logic [scene_pkg::STATUS_W-1:0]     status;
    logic                               busy;
    logic [scene_pkg::ADDR_W-1:0]       rec_addr;
    logic                               reply_start;
    logic [3:0]                         reply_len;
    logic [scene_pkg::REPLY_W-1:0]      reply_val;

    spi_cmd_decoder spi_cmd_decoder_i (
        .sck           (sck),
        .rst           (rst),
        .cs_n_i        (cs_n_i),
        .mosi_i        (mosi_i),
        .accept_i      (accept),
        .base_addr_i   (base_addr),
        .new_id_i      (new_id),
        .status_i      (status),
        .busy_i        (busy),
        .arg_valid_o   (arg_valid),
        .arg_o         (arg),
        .op_o          (op),
        .vert_we_o     (vert_we_o),
        .tri_we_o      (tri_we_o),
        .inst_we_o     (inst_we_o),
        .rec_addr_o    (rec_addr),
        .vert_data_o   (vert_data_o),
        .tri_data_o    (tri_data_o),
        .inst_data_o   (inst_data_o),
        .inst_id_o     (inst_id_o),
        .inst_vbuf_o   (inst_vbuf_o),
        .inst_tbuf_o   (inst_tbuf_o),
        .reply_start_o (reply_start),
        .reply_len_o   (reply_len),
        .reply_val_o   (reply_val)
    );

    buffer_allocator buffer_allocator_i (
        .sck         (sck),
        .rst         (rst),
        .arg_valid_i (arg_valid),
        .arg_i       (arg),
        .op_i        (op),
        .accept_o    (accept),
        .base_addr_o (base_addr),
        .new_id_o    (new_id),
        .status_o    (status)
    );

    reply_serializer reply_serializer_i (
        .sck     (sck),
        .rst     (rst),
        .cs_n_i  (cs_n_i),
        .start_i (reply_start),
        .len_i   (reply_len),
        .value_i (reply_val),
        .miso_o  (miso_o),
        .busy_o  (busy)
    );

    // One address bus, each memory takes its own low bits
    assign vert_addr_o = rec_addr[scene_pkg::VADDR_W-1:0];
    assign tri_addr_o  = rec_addr[scene_pkg::TADDR_W-1:0];

endmodule

// File: verification/raster_spi_link_properties.sv
`timescale 1ns/1ps

module raster_spi_link_properties (
    input logic sck,
    input logic rst,
    input logic cs_n_i,
    input logic miso_i,
    input logic vert_we_i,
    input logic tri_we_i,
    input logic inst_we_i,
    input logic reply_start_i
);

    logic replied;                                 // First reply has been launched

    always_ff @(posedge sck) begin
        if (rst) begin
            replied <= 1'b0;
        end else if (reply_start_i) begin
            replied <= 1'b1;
        end
    end

    one_strobe: assert property (@(posedge sck) disable iff (rst)
        $onehot0({vert_we_i, tri_we_i, inst_we_i}))
        else $error("More than one write strobe high in a cycle");

    no_strobe_deselected: assert property (@(posedge sck) disable iff (rst)
        cs_n_i |-> !(vert_we_i || tri_we_i || inst_we_i))
        else $error("Write strobe high while chip select is inactive");

    miso_idle: assert property (@(posedge sck) disable iff (rst)
        !replied |-> !miso_i)
        else $error("miso_o went high before the first reply");

endmodule

bind raster_spi_link raster_spi_link_properties raster_spi_link_properties_i (
    .sck           (sck),
    .rst           (rst),
    .cs_n_i        (cs_n_i),
    .miso_i        (miso_o),
    .vert_we_i     (vert_we_o),
    .tri_we_i      (tri_we_o),
    .inst_we_i     (inst_we_o),
    .reply_start_i (reply_start)
);

// File: verification/tb_raster_spi_link.sv
`timescale 1ns/1ps

module tb_raster_spi_link;

    typedef struct packed {
        logic [3:0]                       kind;     // Opcode of the memory written
        logic [scene_pkg::VADDR_W-1:0]    addr;
        logic [scene_pkg::ID_W-1:0]       id;
        logic [scene_pkg::ID_W-1:0]       vbuf;
        logic [scene_pkg::ID_W-1:0]       tbuf;
        logic                             chk_ref;  // Only a create carries buffer ids
        logic [scene_pkg::TRANS_W-1:0]    data;
    } write_t;

    logic                              sck;
    logic                              rst;
    logic                              cs_n_i;
    logic [3:0]                        mosi_i;
    logic                              miso_o;
    logic                              vert_we_o;
    logic [scene_pkg::VADDR_W-1:0]     vert_addr_o;
    logic [scene_pkg::VTX_W-1:0]       vert_data_o;
    logic                              tri_we_o;
    logic [scene_pkg::TADDR_W-1:0]     tri_addr_o;
    logic [scene_pkg::TRI_W-1:0]       tri_data_o;
    logic                              inst_we_o;
    logic [scene_pkg::ID_W-1:0]        inst_id_o;
    logic [scene_pkg::ID_W-1:0]        inst_vbuf_o;
    logic [scene_pkg::ID_W-1:0]        inst_tbuf_o;
    logic [scene_pkg::TRANS_W-1:0]     inst_data_o;

    // Reference model state
    int                                vbase;
    int                                tbase;
    logic [scene_pkg::ID_W-1:0]        vbuf_next;
    logic [scene_pkg::ID_W-1:0]        tbuf_next;
    logic [scene_pkg::ID_W-1:0]        inst_next;
    logic                              last_rej;
    write_t                            exp_q[$];
    write_t                            mon_w;

    raster_spi_link raster_spi_link_i (.*);

    initial begin
        sck = 1'b0;
        forever #10 sck = ~sck;
    end

    task automatic stop_run;
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [287:0] got,
                            input logic [287:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [3:0] model_status();
        return {vbase == scene_pkg::VERT_DEPTH, tbase == scene_pkg::TRI_DEPTH,
                inst_next == 8'hFF, last_rej};
    endfunction

    function automatic logic [287:0] rand_record(input int n_nib);
        logic [287:0] v;
        int           i;
        v = '0;
        for (i = 0; i < 9; i++) begin
            v = {v[255:0], $urandom()};
        end
        return v & ({scene_pkg::TRANS_W{1'b1}} >> (scene_pkg::TRANS_W - 4 * n_nib));
    endfunction

    task automatic send_nibble(input logic [3:0] nib);
        @(posedge sck);
        cs_n_i <= 1'b0;
        mosi_i <= nib;
    endtask

    task automatic abort_command;
        @(posedge sck);
        cs_n_i <= 1'b1;                            // Held high for two edges
        mosi_i <= 4'h0;
        @(posedge sck);
    endtask

    task automatic expect_reply(input int len, input logic [11:0] value);
        int k;
        @(posedge sck);                            // Last nibble taken here
        mosi_i <= 4'h0;                            // Not an opcode, so ignored afterwards
        for (k = len - 1; k >= 0; k--) begin
            @(posedge sck);
            @(negedge sck);
            check_eq("miso_o", miso_o, value[k]);
        end
    endtask

    task automatic allocate(input logic [3:0] op, input logic [7:0] cnt, output logic accepted,
                            output int base, output logic [7:0] id);
        accepted = 1'b1;
        base     = 0;
        id       = 8'hFF;
        last_rej = 1'b0;
        if (op == scene_pkg::OP_CREATE_VERT && vbase + cnt <= scene_pkg::VERT_DEPTH) begin
            base      = vbase;
            id        = vbuf_next;
            vbuf_next = vbuf_next + 8'd1;
            vbase     = vbase + cnt;
        end else if (op == scene_pkg::OP_CREATE_TRI && tbase + cnt <= scene_pkg::TRI_DEPTH) begin
            base      = tbase;
            id        = tbuf_next;
            tbuf_next = tbuf_next + 8'd1;
            tbase     = tbase + cnt;
        end else if (op == scene_pkg::OP_CREATE_INST) begin
            id = inst_next;
            if (inst_next != 8'hFF) begin
                inst_next = inst_next + 8'd1;
            end
        end else begin
            accepted = 1'b0;
            last_rej = 1'b1;
        end
    endtask

    // A negative abort_rec lets the command run to its reply
    task automatic send_command(input logic [3:0] op, input logic [15:0] arg,
                                input int abort_rec);
        int                           n_rec;
        int                           n_nib;
        int                           base;
        int                           stop_at;
        int                           k;
        int                           j;
        logic                         accepted;
        logic [7:0]                   id;
        logic [scene_pkg::TRANS_W-1:0] rec;
        write_t                       w;
        send_nibble(op);
        if (op == scene_pkg::OP_UPDATE_INST) begin
            send_nibble(arg[7:4]);
            send_nibble(arg[3:0]);
            accepted = 1'b1;
            base     = 0;
            id       = arg[7:0];
            n_rec    = 1;
        end else begin
            for (k = 3; k >= 0; k--) begin
                send_nibble(arg[4*k +: 4]);
            end
            allocate(op, arg[7:0], accepted, base, id);
            n_rec = (op == scene_pkg::OP_CREATE_INST) ? 1 : int'(arg[7:0]);
        end
        case (op)
            scene_pkg::OP_CREATE_VERT: n_nib = scene_pkg::VTX_NIB;
            scene_pkg::OP_CREATE_TRI:  n_nib = scene_pkg::TRI_NIB;
            default:                   n_nib = scene_pkg::TRANS_NIB;
        endcase
        stop_at = 1 + int'($urandom_range(n_nib - 2));  // Always inside a record
        for (k = 0; k < n_rec; k++) begin
            rec = rand_record(n_nib);
            for (j = n_nib - 1; j >= 0; j--) begin
                send_nibble(rec[4*j +: 4]);
                if (k == abort_rec && j == n_nib - stop_at) begin
                    abort_command();
                    return;
                end
            end
            if (accepted) begin
                w.kind    = (op == scene_pkg::OP_UPDATE_INST) ? scene_pkg::OP_CREATE_INST : op;
                w.addr    = scene_pkg::VADDR_W'(base + k);
                w.id      = id;
                w.vbuf    = arg[15:8];
                w.tbuf    = arg[7:0];
                w.chk_ref = (op == scene_pkg::OP_CREATE_INST);
                w.data    = rec;
                exp_q.push_back(w);
            end
        end
        if (op == scene_pkg::OP_UPDATE_INST) begin
            expect_reply(4, {8'h00, model_status()});
        end else begin
            expect_reply(12, {id, model_status()});
        end
    endtask

    task automatic wait_drained;
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            assert (n < 100) else begin
                $display("Timed out waiting for expected write strobes");
                stop_run();
            end
            @(negedge sck);
            n++;
        end
    endtask

    always @(negedge sck) begin
        if (!rst && (vert_we_o || tri_we_o || inst_we_o)) begin
            assert (exp_q.size() != 0) else begin
                $display("A write strobe fired while no write was expected");
                stop_run();
            end
            mon_w = exp_q.pop_front();
            check_eq("vert_we_o", vert_we_o, mon_w.kind == scene_pkg::OP_CREATE_VERT);
            check_eq("tri_we_o", tri_we_o, mon_w.kind == scene_pkg::OP_CREATE_TRI);
            check_eq("inst_we_o", inst_we_o, mon_w.kind == scene_pkg::OP_CREATE_INST);
            if (vert_we_o) begin
                check_eq("vert_addr_o", vert_addr_o, mon_w.addr);
                check_eq("vert_data_o", vert_data_o, mon_w.data);
            end else if (tri_we_o) begin
                check_eq("tri_addr_o", tri_addr_o, mon_w.addr);
                check_eq("tri_data_o", tri_data_o, mon_w.data);
            end else begin
                check_eq("inst_id_o", inst_id_o, mon_w.id);
                check_eq("inst_data_o", inst_data_o, mon_w.data);
                if (mon_w.chk_ref) begin
                    check_eq("inst_vbuf_o", inst_vbuf_o, mon_w.vbuf);
                    check_eq("inst_tbuf_o", inst_tbuf_o, mon_w.tbuf);
                end
            end
        end
    end

    initial begin
        int         i;
        int         sel;
        int         cnt;
        int         abort_rec;
        logic [3:0] op;
        void'($urandom(4030));
        rst       = 1'b1;
        cs_n_i    = 1'b1;
        mosi_i    = 4'h0;
        vbase     = 0;
        tbase     = 0;
        vbuf_next = 8'd0;
        tbuf_next = 8'd0;
        inst_next = 8'd1;
        last_rej  = 1'b0;
        repeat (10) @(posedge sck);
        rst <= 1'b0;

        for (i = 0; i < 60; i++) begin
            sel = int'($urandom_range(7));
            cnt = int'($urandom_range(40));
            case (sel)
                0, 1: send_command(scene_pkg::OP_CREATE_VERT, {8'h00, 8'(cnt)}, -1);
                2, 3: send_command(scene_pkg::OP_CREATE_TRI, {8'h00, 8'(cnt)}, -1);
                4:    send_command(scene_pkg::OP_CREATE_INST, 16'($urandom()), -1);
                5:    send_command(scene_pkg::OP_UPDATE_INST, {8'h00, 8'($urandom())}, -1);
                6:    send_nibble(4'($urandom_range(15, 5)));   // Unknown opcode
                default: begin
                    op        = 4'($urandom_range(3, 1));
                    abort_rec = (op == scene_pkg::OP_CREATE_INST) ? 0 : int'($urandom_range(cnt));
                    send_command(op, {8'h00, 8'(cnt + 1)}, abort_rec);
                end
            endcase
            wait_drained();
        end

        // Fill vertex memory, then push past its depth
        for (i = 0; i < 8 && vbase + 250 <= scene_pkg::VERT_DEPTH; i++) begin
            send_command(scene_pkg::OP_CREATE_VERT, {8'h00, 8'd250}, -1);
            wait_drained();
        end
        send_command(scene_pkg::OP_CREATE_VERT, {8'h00, 8'd250}, -1);
        if (vbase < scene_pkg::VERT_DEPTH) begin
            send_command(scene_pkg::OP_CREATE_VERT,
                         {8'h00, 8'(scene_pkg::VERT_DEPTH - vbase)}, -1);
            wait_drained();
        end
        send_command(scene_pkg::OP_CREATE_VERT, {8'h00, 8'd1}, -1);
        send_command(scene_pkg::OP_CREATE_VERT, {8'h00, 8'd0}, -1);
        send_command(scene_pkg::OP_CREATE_TRI, {8'h00, 8'd3}, -1);
        wait_drained();

        $display("TEST OK");
        $finish;
    end

endmodule

// File: verilog.f
rtl/scene_pkg.sv
rtl/spi_cmd_decoder.sv
rtl/buffer_allocator.sv
rtl/reply_serializer.sv
rtl/raster_spi_link.sv
verification/raster_spi_link_properties.sv
verification/tb_raster_spi_link.sv
